//--- include/mmu_config.svh
`ifndef MMU_CONFIG_SVH
`define MMU_CONFIG_SVH

// tlb size
`define MMU_TLB_ENTRIES 16

// crmd fields
`define CRMD_PLV  1:0
`define CRMD_DA   3
`define CRMD_DATF 6:5   // fetch mat in da mode
`define CRMD_DATM 8:7   // load/store mat in da mode

// direct mapped window fields
`define DMW_PLV0 0
`define DMW_PLV3 3
`define DMW_MAT  5:4
`define DMW_PSEG 27:25
`define DMW_VSEG 31:29

// access types
`define MEM_FETCH 2'd0
`define MEM_LOAD  2'd1
`define MEM_STORE 2'd2

// exception codes
`define ECODE_TLBR 6'h3f
`define ECODE_PIL  6'h01
`define ECODE_PIS  6'h02
`define ECODE_PIF  6'h03
`define ECODE_PME  6'h04
`define ECODE_PPI  6'h07

`endif

//--- design/mmu_pkg.sv
package mmu_pkg;

    // match part of a tlb entry
    // vppn covers va[31:13]; for a huge page only vppn[18:10] is compared
    typedef struct packed {
        logic        e;          // entry exists
        logic [18:0] vppn;
        logic [9:0]  asid;
        logic        g;          // global, ignores asid
        logic        huge_page;  // 4 MB pair instead of 4 KB pair
    } tlb_key_t;

    // one page of the even/odd pair
    typedef struct packed {
        logic [19:0] ppn;
        logic        v;          // valid
        logic        d;          // dirty, store allowed
        logic [1:0]  plv;        // lowest privilege allowed
        logic [1:0]  mat;
    } tlb_value_t;

    // full entry as written and read back by software
    typedef struct packed {
        tlb_key_t   key;
        tlb_value_t even;        // selected when the page bit is 0
        tlb_value_t odd;         // selected when the page bit is 1
    } tlb_entry_t;

    // registered output of the translator
    // pa and mat are zero whenever ecode is nonzero
    typedef struct packed {
        logic [31:0] pa;
        logic [1:0]  mat;
        logic [5:0]  ecode;
    } trans_result_t;

endpackage

//--- design/tlb_lookup_if.sv
`timescale 1ns/10ps

// combinational lookup path between translator and tlb array
interface tlb_lookup_if;
    import mmu_pkg::*;

    logic [31:0] va;
    logic [9:0]  asid;
    logic        hit;
    tlb_value_t  page;       // even or odd page already picked
    logic        huge_page;

    modport requester (
        output va,
        output asid,
        input  hit,
        input  page,
        input  huge_page
    );

    modport responder (
        input  va,
        input  asid,
        output hit,
        output page,
        output huge_page
    );

endinterface

//--- design/tlb_array.sv
`timescale 1ns/10ps

module tlb_array #(
    parameter int unsigned ENTRIES = 16
) (
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic                       wr_en_i,
    input  logic [$clog2(ENTRIES)-1:0] wr_index_i,
    input  mmu_pkg::tlb_entry_t        wr_entry_i,
    input  logic [$clog2(ENTRIES)-1:0] rd_index_i,
    output mmu_pkg::tlb_entry_t        rd_entry_o,
    tlb_lookup_if.responder            lookup
);
    import mmu_pkg::*;

    localparam int unsigned IDX_W = $clog2(ENTRIES);

    tlb_entry_t         entries_q [ENTRIES];  // key and pages, no reset
    logic [ENTRIES-1:0] exist_q;               // e bits live here
    logic [ENTRIES-1:0] match;
    logic               hit;
    logic [IDX_W-1:0]   hit_idx;
    tlb_entry_t         hit_entry;
    logic               odd_sel;
    tlb_entry_t         rd_sel;

    function automatic logic vppn_hit(input logic [31:0] va, input tlb_key_t key);
        if (key.huge_page) begin
            return va[31:23] == key.vppn[18:10];  // 4 MB pair
        end
        return va[31:13] == key.vppn;             // 4 KB pair
    endfunction

    always_ff @(posedge clk) begin
        if (reset_i) begin
            exist_q <= '0;
        end else if (wr_en_i) begin
            exist_q[wr_index_i] <= wr_entry_i.key.e;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            entries_q[wr_index_i] <= wr_entry_i;
        end
    end

    // parallel compare of all keys
    always_comb begin
        for (int i = 0; i < ENTRIES; i++) begin
            match[i] = exist_q[i]
                       && (entries_q[i].key.g || entries_q[i].key.asid == lookup.asid)
                       && vppn_hit(lookup.va, entries_q[i].key);
        end
    end

    // lowest index wins, so scan downwards
    always_comb begin
        hit     = 1'b0;
        hit_idx = '0;
        for (int i = ENTRIES - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit     = 1'b1;
                hit_idx = IDX_W'(i);
            end
        end
    end

    assign hit_entry = entries_q[hit_idx];
    assign odd_sel   = hit_entry.key.huge_page ? lookup.va[22] : lookup.va[12];

    assign lookup.hit       = hit;
    assign lookup.page      = !hit ? '0 : (odd_sel ? hit_entry.odd : hit_entry.even);
    assign lookup.huge_page = hit && hit_entry.key.huge_page;

    // read-back with the live exist bit
    always_comb begin
        rd_sel       = entries_q[rd_index_i];
        rd_sel.key.e = exist_q[rd_index_i];
    end

    always_ff @(posedge clk) begin
        rd_entry_o <= rd_sel;  // one cycle read latency
    end

endmodule

//--- design/dmw_match.sv
`timescale 1ns/10ps
`include "mmu_config.svh"

module dmw_match (
    input  logic [31:0] va_i,
    input  logic [1:0]  plv_i,
    input  logic [31:0] dmw0_i,
    input  logic [31:0] dmw1_i,
    output logic        hit_o,
    output logic [2:0]  pseg_o,
    output logic [1:0]  mat_o
);

    logic dmw0_hit;
    logic dmw1_hit;

    // segment match plus the plv enable for plv0 or plv3
    // plv1 and plv2 never hit a window
    function automatic logic window_hit(input logic [31:0] dmw,
                                        input logic [31:0] va,
                                        input logic [1:0]  plv);
        logic plv_ok;
        plv_ok = (plv == 2'd0 && dmw[`DMW_PLV0]) || (plv == 2'd3 && dmw[`DMW_PLV3]);
        return plv_ok && (dmw[`DMW_VSEG] == va[31:29]);
    endfunction

    assign dmw0_hit = window_hit(dmw0_i, va_i, plv_i);
    assign dmw1_hit = window_hit(dmw1_i, va_i, plv_i);

    assign hit_o = dmw0_hit || dmw1_hit;

    always_comb begin
        pseg_o = '0;
        mat_o  = '0;
        if (dmw0_hit) begin  // dmw0 has priority
            pseg_o = dmw0_i[`DMW_PSEG];
            mat_o  = dmw0_i[`DMW_MAT];
        end else if (dmw1_hit) begin
            pseg_o = dmw1_i[`DMW_PSEG];
            mat_o  = dmw1_i[`DMW_MAT];
        end
    end

endmodule

//--- design/addr_translate.sv
`timescale 1ns/10ps
`include "mmu_config.svh"

module addr_translate (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  flush_i,
    input  logic                  req_valid_i,
    input  logic [31:0]           va_i,
    input  logic [1:0]            mem_type_i,
    input  logic [31:0]           crmd_i,
    input  logic [9:0]            asid_i,
    input  logic                  dmw_hit_i,
    input  logic [2:0]            dmw_pseg_i,
    input  logic [1:0]            dmw_mat_i,
    tlb_lookup_if.requester       lookup,
    output logic                  res_valid_o,
    output mmu_pkg::trans_result_t result_o
);
    import mmu_pkg::*;

    logic [1:0]    cur_plv;
    logic          da_mode;
    tlb_value_t    page;
    logic [31:0]   tlb_pa;
    logic [5:0]    tlb_ecode;
    trans_result_t next_result;

    assign cur_plv = crmd_i[`CRMD_PLV];
    assign da_mode = crmd_i[`CRMD_DA];

    // tlb is probed every cycle, result only used when nothing else hits
    assign lookup.va   = va_i;
    assign lookup.asid = asid_i;
    assign page        = lookup.page;

    assign tlb_pa = lookup.huge_page ? {page.ppn[19:10], va_i[21:0]}
                                     : {page.ppn, va_i[11:0]};

    // exception checks in priority order
    always_comb begin
        tlb_ecode = 6'h00;
        if (!lookup.hit) begin
            tlb_ecode = `ECODE_TLBR;
        end else if (!page.v) begin
            case (mem_type_i)
                `MEM_FETCH: tlb_ecode = `ECODE_PIF;
                `MEM_STORE: tlb_ecode = `ECODE_PIS;
                default:    tlb_ecode = `ECODE_PIL;
            endcase
        end else if (cur_plv > page.plv) begin
            tlb_ecode = `ECODE_PPI;
        end else if (mem_type_i == `MEM_STORE && !page.d) begin
            tlb_ecode = `ECODE_PME;  // first store to a clean page
        end
    end

    always_comb begin
        next_result = '0;
        if (da_mode) begin
            next_result.pa  = va_i;
            next_result.mat = (mem_type_i == `MEM_FETCH) ? crmd_i[`CRMD_DATF]
                                                         : crmd_i[`CRMD_DATM];
        end else if (dmw_hit_i) begin
            next_result.pa  = {dmw_pseg_i, va_i[28:0]};
            next_result.mat = dmw_mat_i;
        end else begin
            next_result.ecode = tlb_ecode;
            if (tlb_ecode == 6'h00) begin  // pa and mat stay zero on a fault
                next_result.pa  = tlb_pa;
                next_result.mat = page.mat;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            res_valid_o <= 1'b0;
            result_o    <= '0;
        end else begin
            res_valid_o <= req_valid_i;
            if (req_valid_i) begin
                result_o <= next_result;
            end
        end
    end

endmodule

//--- design/mmu_top.sv
`timescale 1ns/10ps
`include "mmu_config.svh"

module mmu_top (
    input  logic                                clk,
    input  logic                                reset_i,
    input  logic                                flush_i,
    input  logic                                req_valid_i,
    input  logic [31:0]                         va_i,
    input  logic [1:0]                          mem_type_i,
    input  logic [31:0]                         crmd_i,
    input  logic [9:0]                          asid_i,
    input  logic [31:0]                         dmw0_i,
    input  logic [31:0]                         dmw1_i,
    input  logic                                tlb_wr_en_i,
    input  logic [$clog2(`MMU_TLB_ENTRIES)-1:0] tlb_wr_index_i,
    input  mmu_pkg::tlb_entry_t                 tlb_wr_entry_i,
    input  logic [$clog2(`MMU_TLB_ENTRIES)-1:0] tlb_rd_index_i,
    output logic                                res_valid_o,
    output logic [31:0]                         pa_o,
    output logic [1:0]                          mat_o,
    output logic [5:0]                          ecode_o,
    output mmu_pkg::tlb_entry_t                 tlb_rd_entry_o
);
    import mmu_pkg::*;

    logic          dmw_hit;
    logic [2:0]    dmw_pseg;
    logic [1:0]    dmw_mat;
    trans_result_t result;

    tlb_lookup_if lookup_if ();

    tlb_array #(
        .ENTRIES (`MMU_TLB_ENTRIES)
    ) tlb_array_inst (
        .clk        (clk),
        .reset_i    (reset_i),
        .wr_en_i    (tlb_wr_en_i),
        .wr_index_i (tlb_wr_index_i),
        .wr_entry_i (tlb_wr_entry_i),
        .rd_index_i (tlb_rd_index_i),
        .rd_entry_o (tlb_rd_entry_o),
        .lookup     (lookup_if.responder)
    );

    dmw_match dmw_match_inst (
        .va_i   (va_i),
        .plv_i  (crmd_i[`CRMD_PLV]),  // current privilege level
        .dmw0_i (dmw0_i),
        .dmw1_i (dmw1_i),
        .hit_o  (dmw_hit),
        .pseg_o (dmw_pseg),
        .mat_o  (dmw_mat)
    );

    addr_translate addr_translate_inst (
        .clk         (clk),
        .reset_i     (reset_i),
        .flush_i     (flush_i),
        .req_valid_i (req_valid_i),
        .va_i        (va_i),
        .mem_type_i  (mem_type_i),
        .crmd_i      (crmd_i),
        .asid_i      (asid_i),
        .dmw_hit_i   (dmw_hit),
        .dmw_pseg_i  (dmw_pseg),
        .dmw_mat_i   (dmw_mat),
        .lookup      (lookup_if.requester),
        .res_valid_o (res_valid_o),
        .result_o    (result)
    );

    assign pa_o    = result.pa;
    assign mat_o   = result.mat;
    assign ecode_o = result.ecode;

endmodule

//--- test/tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
    output logic clk_o
);

    localparam real HALF_PERIOD = 4.0;  // 8 ns period

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

endmodule

//--- test/mmu_tb.sv
`timescale 1ns/10ps
`include "mmu_config.svh"

module mmu_tb;
    import mmu_pkg::*;

    localparam int IDX_W          = $clog2(`MMU_TLB_ENTRIES);
    localparam int STIM_CYCLES    = 116;  // reset plus all six test groups
    localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES;

    localparam logic [31:0] CRMD_DA_MODE = 32'h0000_0128;  // da, datf 1, datm 2
    localparam logic [31:0] DMW0_A       = 32'h8000_0011;  // seg 4 to 0, mat 1, plv0
    localparam logic [31:0] DMW1_A       = 32'hA200_0009;  // seg 5 to 1, mat 0, plv0 and plv3
    localparam logic [31:0] DMW1_B       = 32'h8600_0029;  // seg 4 to 3, mat 2, plv0 and plv3

    logic clk;
    logic reset_i, flush_i, req_valid_i, tlb_wr_en_i;
    logic [31:0] va_i, crmd_i, dmw0_i, dmw1_i, pa_o;
    logic [1:0] mem_type_i, mat_o;
    logic [9:0] asid_i;
    logic [IDX_W-1:0] tlb_wr_index_i, tlb_rd_index_i;
    tlb_entry_t tlb_wr_entry_i, tlb_rd_entry_o;
    logic res_valid_o;
    logic [5:0] ecode_o;

    logic rd_check;  // read-back expected on the next edge
    logic [31:0] lfsr = 32'h5253;
    int error_count = 0;
    int cycles = 0;

    tlb_entry_t ref_tlb [`MMU_TLB_ENTRIES];
    tlb_entry_t written [8];
    logic armed = 1'b0;
    logic exp_valid, exp_zero, exp_rd_chk;
    trans_result_t exp_res;
    tlb_entry_t exp_rd;

    tb_clock tb_clock_inst (.clk_o(clk));

    mmu_top mmu_top_inst (
        .clk(clk), .reset_i(reset_i), .flush_i(flush_i), .req_valid_i(req_valid_i),
        .va_i(va_i), .mem_type_i(mem_type_i), .crmd_i(crmd_i), .asid_i(asid_i),
        .dmw0_i(dmw0_i), .dmw1_i(dmw1_i), .tlb_wr_en_i(tlb_wr_en_i),
        .tlb_wr_index_i(tlb_wr_index_i), .tlb_wr_entry_i(tlb_wr_entry_i),
        .tlb_rd_index_i(tlb_rd_index_i), .res_valid_o(res_valid_o), .pa_o(pa_o),
        .mat_o(mat_o), .ecode_o(ecode_o), .tlb_rd_entry_o(tlb_rd_entry_o)
    );

    // galois lfsr, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic window_on(input logic [31:0] dmw, input logic [31:0] va,
                                       input logic [1:0] plv);
        return (dmw[`DMW_VSEG] == va[31:29])
               && ((plv == 2'd0 && dmw[`DMW_PLV0]) || (plv == 2'd3 && dmw[`DMW_PLV3]));
    endfunction

    // expected translation from the priority rules and the reference tlb
    function automatic trans_result_t expect_result(input logic [31:0] va,
            input logic [1:0] mt, input logic [31:0] crmd, input logic [9:0] asid,
            input logic [31:0] dmw0, input logic [31:0] dmw1);
        trans_result_t r;
        logic [1:0] plv;
        logic found;
        tlb_entry_t ent;
        tlb_value_t pg;
        r     = '0;
        plv   = crmd[`CRMD_PLV];
        found = 1'b0;
        ent   = '0;
        if (crmd[`CRMD_DA]) begin
            r.pa  = va;
            r.mat = (mt == `MEM_FETCH) ? crmd[`CRMD_DATF] : crmd[`CRMD_DATM];
            return r;
        end
        if (window_on(dmw0, va, plv) || window_on(dmw1, va, plv)) begin
            r.pa  = window_on(dmw0, va, plv) ? {dmw0[`DMW_PSEG], va[28:0]}
                                             : {dmw1[`DMW_PSEG], va[28:0]};
            r.mat = window_on(dmw0, va, plv) ? dmw0[`DMW_MAT] : dmw1[`DMW_MAT];
            return r;
        end
        for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
            if (!found && ref_tlb[i].key.e
                && (ref_tlb[i].key.g || ref_tlb[i].key.asid == asid)
                && (ref_tlb[i].key.huge_page ? (va[31:23] == ref_tlb[i].key.vppn[18:10])
                                             : (va[31:13] == ref_tlb[i].key.vppn))) begin
                found = 1'b1;
                ent   = ref_tlb[i];
            end
        end
        if (!found) begin
            r.ecode = `ECODE_TLBR;
            return r;
        end
        pg = (ent.key.huge_page ? va[22] : va[12]) ? ent.odd : ent.even;
        if (!pg.v) begin
            r.ecode = (mt == `MEM_FETCH) ? `ECODE_PIF
                    : (mt == `MEM_STORE) ? `ECODE_PIS : `ECODE_PIL;
        end else if (plv > pg.plv) begin
            r.ecode = `ECODE_PPI;
        end else if (mt == `MEM_STORE && !pg.d) begin
            r.ecode = `ECODE_PME;
        end else begin
            r.pa  = ent.key.huge_page ? {pg.ppn[19:10], va[21:0]} : {pg.ppn, va[11:0]};
            r.mat = pg.mat;
        end
        return r;
    endfunction

    // valid, present, full access pages with random ppn and mat
    function automatic tlb_entry_t make_entry(input logic huge, input logic is_global,
                                              input logic [9:0] asid);
        tlb_entry_t ent;
        logic [31:0] r;
        ent               = '0;
        r                 = rand_bits(19);
        ent.key           = '{e: 1'b1, vppn: r[18:0], asid: asid, g: is_global, huge_page: huge};
        r                 = rand_bits(22);
        ent.even          = '{ppn: r[19:0], v: 1'b1, d: 1'b1, plv: 2'd3, mat: r[21:20]};
        r                 = rand_bits(22);
        ent.odd           = '{ppn: r[19:0], v: 1'b1, d: 1'b1, plv: 2'd3, mat: r[21:20]};
        return ent;
    endfunction

    function automatic logic [31:0] page_va(input tlb_entry_t ent, input logic odd);
        logic [31:0] r;
        r = rand_bits(22);
        return ent.key.huge_page ? {ent.key.vppn[18:10], odd, r[21:0]}
                                 : {ent.key.vppn, odd, r[11:0]};
    endfunction

    task automatic check_value(input string name, input logic [127:0] exp_v,
                               input logic [127:0] act_v);
        assert (act_v === exp_v) else begin
            $display("FAILED %s: expected 0x%0h, got 0x%0h", name, exp_v, act_v);
            error_count++;
        end
    endtask

    // compare what the last edge produced, then predict the next edge
    always @(negedge clk) begin
        if (armed) begin
            check_value("res_valid_o", 128'(exp_valid), 128'(res_valid_o));
            if (exp_valid) begin
                check_value("pa_o", 128'(exp_res.pa), 128'(pa_o));
                check_value("mat_o", 128'(exp_res.mat), 128'(mat_o));
                check_value("ecode_o", 128'(exp_res.ecode), 128'(ecode_o));
            end else if (exp_zero) begin
                check_value("ecode_o", 128'(0), 128'(ecode_o));
            end
            if (exp_rd_chk) begin
                check_value("tlb_rd_entry_o", 128'(exp_rd), 128'(tlb_rd_entry_o));
            end
        end
        exp_rd_chk = rd_check;
        exp_rd     = ref_tlb[tlb_rd_index_i];
        exp_zero   = reset_i;
        exp_valid  = !reset_i && !flush_i && req_valid_i;
        if (exp_valid) begin
            exp_res = expect_result(va_i, mem_type_i, crmd_i, asid_i, dmw0_i, dmw1_i);
        end
        if (tlb_wr_en_i) begin
            ref_tlb[tlb_wr_index_i] = tlb_wr_entry_i;  // visible from the next lookup on
        end
        if (reset_i) begin
            for (int i = 0; i < `MMU_TLB_ENTRIES; i++) ref_tlb[i].key.e = 1'b0;
        end
        armed = 1'b1;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic quiet_controls();
        req_valid_i <= 1'b0;
        flush_i     <= 1'b0;
        tlb_wr_en_i <= 1'b0;
        rd_check    <= 1'b0;
    endtask

    task automatic issue(input logic [31:0] va, input logic [1:0] mt, input logic [9:0] asid,
                         input logic flush = 1'b0);
        @(posedge clk);
        quiet_controls();
        req_valid_i <= 1'b1;
        flush_i     <= flush;
        va_i        <= va;
        mem_type_i  <= mt;
        asid_i      <= asid;
    endtask

    task automatic write_entry(input int idx, input tlb_entry_t ent);
        @(posedge clk);
        quiet_controls();
        tlb_wr_en_i    <= 1'b1;
        tlb_wr_index_i <= IDX_W'(idx);
        tlb_wr_entry_i <= ent;
    endtask

    task automatic read_entry(input int idx);
        @(posedge clk);
        quiet_controls();
        tlb_rd_index_i <= IDX_W'(idx);
        rd_check       <= 1'b1;
    endtask

    task automatic set_csr(input logic [31:0] crmd, input logic [31:0] dmw0,
                           input logic [31:0] dmw1);
        @(posedge clk);
        quiet_controls();
        crmd_i <= crmd;
        dmw0_i <= dmw0;
        dmw1_i <= dmw1;
    endtask

    initial begin
        tlb_entry_t ent;
        logic [31:0] r;
        {flush_i, req_valid_i, tlb_wr_en_i, rd_check} = '0;
        {va_i, crmd_i, dmw0_i, dmw1_i, mem_type_i, asid_i} = '0;
        {tlb_wr_index_i, tlb_rd_index_i, tlb_wr_entry_i} = '0;
        for (int i = 0; i < `MMU_TLB_ENTRIES; i++) ref_tlb[i] = '0;
        reset_i = 1'b1;
        repeat (8) @(posedge clk);
        reset_i <= 1'b0;

        // empty tlb, paging on, no windows
        repeat (4) issue(rand_bits(32), `MEM_LOAD, 10'h0);

        // direct addressing with random access types
        set_csr(CRMD_DA_MODE, 32'h0, 32'h0);
        repeat (24) begin
            r = rand_bits(2);
            issue(rand_bits(32), (r[1:0] == 2'd3) ? `MEM_LOAD : r[1:0], 10'h0);
        end

        // windows at plv0 and plv3, then both windows on segment 4
        for (int pass = 0; pass < 4; pass++) begin
            set_csr((pass % 2 == 0) ? 32'h0 : 32'h3, DMW0_A, (pass < 2) ? DMW1_A : DMW1_B);
            for (int k = 0; k < 4; k++) begin
                r = rand_bits(29);
                issue({2'b10, k[0], r[28:0]}, `MEM_LOAD, 10'h0);  // segments 4 and 5
            end
        end

        // random small and huge pairs, back to back lookups and read-back
        set_csr(32'h0, 32'h0, 32'h0);
        for (int i = 0; i < 8; i++) begin
            r          = rand_bits(10);
            written[i] = make_entry(i[0], (i % 4) == 0, r[9:0]);
            write_entry(i, written[i]);
        end
        for (int i = 0; i < 8; i++) begin
            issue(page_va(written[i], 1'b0), `MEM_LOAD, written[i].key.asid);
            issue(page_va(written[i], 1'b1), `MEM_STORE, written[i].key.asid);
        end
        for (int i = 0; i < 8; i++) begin
            issue(page_va(written[i], 1'b0), `MEM_FETCH, written[i].key.asid ^ 10'h155);
        end
        for (int i = 0; i < 8; i++) read_entry(i);

        // faults at plv3, each lookup right after its write
        set_csr(32'h3, 32'h0, 32'h0);
        ent          = make_entry(1'b0, 1'b1, 10'h0);
        ent.even.v   = 1'b0;
        ent.odd.d    = 1'b0;
        write_entry(8, ent);
        issue(page_va(ent, 1'b0), `MEM_FETCH, 10'h0);
        issue(page_va(ent, 1'b0), `MEM_LOAD, 10'h0);
        issue(page_va(ent, 1'b0), `MEM_STORE, 10'h0);
        issue(page_va(ent, 1'b1), `MEM_STORE, 10'h0);
        issue(page_va(ent, 1'b1), `MEM_LOAD, 10'h0);
        ent          = make_entry(1'b1, 1'b1, 10'h0);
        ent.even.plv = 2'd0;
        write_entry(9, ent);
        issue(page_va(ent, 1'b0), `MEM_LOAD, 10'h0);
        issue(page_va(ent, 1'b1), `MEM_STORE, 10'h0);

        // flush next to a request, and an overwrite seen by the next lookup
        issue(page_va(ent, 1'b1), `MEM_LOAD, 10'h0);
        issue(page_va(ent, 1'b1), `MEM_LOAD, 10'h0, 1'b1);
        issue(page_va(ent, 1'b1), `MEM_FETCH, 10'h0, 1'b1);
        ent.odd.ppn = ent.odd.ppn ^ 20'hfffff;
        write_entry(9, ent);
        issue(page_va(ent, 1'b1), `MEM_LOAD, 10'h0);
        set_csr(32'h3, 32'h0, 32'h0);
        repeat (2) set_csr(32'h3, 32'h0, 32'h0);

        $display("checks done, errors: %0d", error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+include
design/mmu_pkg.sv
design/tlb_lookup_if.sv
design/tlb_array.sv
design/dmw_match.sv
design/addr_translate.sv
design/mmu_top.sv
test/tb_clock.sv
test/mmu_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f src.f --top-module mmu_tb -Mdir obj_dir \
    && ./obj_dir/Vmmu_tb > sim.log 2>&1 \
    || echo "STATUS: FAIL" >> sim.log
cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1
exit 0
